//--- verif/lut_patterns.txt
# test kind, then hex fields: W paddr pwdata pstrb pslverr overlap | R paddr
# L idx0 idx1 val0 val1 random_gap (overlap = following L records streamed during the write)
# unwritten entries right after reset
1 L 00000000 00000001 00000000 00000000 0
1 L 000000ff 00000080 00000000 00000000 0
# in-range writes, any strobe writes the whole word
2 W 00000000 11111111 f 0 0
2 W 00000004 deadbeef 1 0 0
2 W 000003fc cafef00d f 0 0
2 W 00000080 12345678 8 0 0
2 L 00000000 00000001 11111111 deadbeef 0
2 L 000000ff 00000020 cafef00d 12345678 0
# rejected accesses leave the table alone
3 W 00000400 badbad01 f 1 0
3 W 000007fc badbad02 f 1 0
3 W 00000008 badbad03 0 1 0
3 R 00000000
3 R 000003fc
3 L 00000000 000000ff 11111111 cafef00d 0
3 L 00000002 00000001 00000000 deadbeef 0
# back-to-back beats, equal indices, high index bits ignored
4 L 00000001 00000001 deadbeef deadbeef 0
4 L 00000000 00000000 11111111 11111111 0
4 L 00000100 ffffff20 11111111 12345678 0
4 L abcd00ff 00000104 cafef00d 00000000 0
4 L 00000020 00000020 12345678 12345678 0
4 L 00000001 00000000 deadbeef 11111111 0
# write lands under a lookup stream, two beats before it, two after
5 W 00000014 55550000 f 0 0
5 L 00000005 00000005 55550000 55550000 0
5 W 00000014 5555ffff f 0 4
5 L 00000005 00000000 55550000 11111111 0
5 L 00000001 00000005 deadbeef 55550000 0
5 L 00000005 00000005 5555ffff 5555ffff 0
5 L 00000305 00000001 5555ffff deadbeef 0
5 L 00000005 00000020 5555ffff 12345678 0
# unwritten entries mixed with written ones, random idle gaps
6 L 00000010 00000011 00000000 00000000 1
6 L 00000000 0000007f 11111111 00000000 1
6 L 000000fe 00000003 00000000 00000000 1
6 L 00000040 000000ff 00000000 cafef00d 1
6 L 00000002 00000004 00000000 00000000 1
6 L 12345680 00000005 00000000 5555ffff 1

//--- sources.f
+incdir+hdl
hdl/lut_pkg.sv
hdl/lut_dp_ram.sv
hdl/lut_apb_port.sv
hdl/lut_unit.sv
hdl/lut_top.sv
verif/lut_checker.sv
verif/tb_lut.sv

//--- run_sim.sh
#!/bin/sh
# builds the LUT testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
      --top-module tb_lut -o tb_lut; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_lut)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
   exit 0
fi
exit 1

//--- verif/tb_lut.sv
`include "lut_consts.svh"

module tb_lut
   import lut_pkg::*;
();

   logic                   clk = 1'b0;
   logic                   rst;
   logic [31:0]            paddr;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`LUT_DATA_W-1:0] pwdata;
   logic [`LUT_STRB_W-1:0] pstrb;
   logic [`LUT_DATA_W-1:0] prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   in_valid;
   lut_req_t               in_req;
   logic                   in_ready;
   logic                   out_valid;
   lut_rsp_t               out_rsp;

   logic [31:0] rng = 32'hf9bc50bf;
   logic        aborted = 1'b0;
   int          fd;
   int          cur_test = 0;
   int          err_base = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   int          rec_t;                  // current pattern record
   logic [7:0]  rec_kind;
   logic [31:0] rec_a;
   logic [31:0] rec_b;
   logic [31:0] rec_c;
   logic [31:0] rec_d;
   logic [31:0] rec_e;

   always #4 clk = ~clk;

   lut_top dut0 (
      .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
      .pready(pready), .pslverr(pslverr), .in_valid(in_valid), .in_req(in_req),
      .in_ready(in_ready), .out_valid(out_valid), .out_rsp(out_rsp)
   );

   lut_checker chk0 (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
      .pslverr(pslverr), .prdata(prdata), .in_valid(in_valid), .in_ready(in_ready),
      .out_valid(out_valid), .out_rsp(out_rsp)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic abort_run(input string what);
      aborted = 1'b1;
      $display("%s", what);
   endtask

   // ############################
   // bus drivers
   // ############################

   task automatic apb_access(input logic [31:0] addr, input logic [31:0] data,
                             input logic [`LUT_STRB_W-1:0] strb, input logic wr, input logic err);
      int   n;
      logic rdy;
      chk0.expect_apb(err);
      paddr   = addr;
      pwdata  = data;
      pstrb   = strb;
      pwrite  = wr;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      rdy = 1'b0;
      n   = 0;
      while (!rdy && n < 20) begin
         rdy = pready;   // stable through the cycle
         @(posedge clk);
         #1;
         n++;
      end
      if (!rdy) begin
         abort_run("timeout waiting for pready");
      end else begin
         psel    = 1'b0;
         penable = 1'b0;
      end
   endtask

   task automatic send_beat(input logic [31:0] i0, input logic [31:0] i1,
                            input logic [31:0] v0, input logic [31:0] v1, input logic rnd);
      int   n;
      logic ok;
      if (rnd) begin
         rng = lcg_next(rng);
         repeat (rng[31:30]) begin   // 0 to 3 idle cycles
            @(posedge clk);
            #1;
         end
      end
      in_valid = 1'b1;
      in_req   = '{idx0: i0, idx1: i1};
      chk0.expect_rsp(v0, v1);
      ok = 1'b0;
      n  = 0;
      while (!ok && n < 20) begin
         ok = in_ready;
         @(posedge clk);
         #1;
         n++;
      end
      if (!ok) begin
         abort_run("timeout waiting for in_ready");
      end else begin
         in_valid = 1'b0;
      end
   endtask

   // ############################
   // pattern file
   // ############################

   task automatic read_record(output logic ok);
      logic [8*160-1:0] line;
      int               n;
      ok = 1'b0;
      while (!ok && !$feof(fd)) begin
         line = '0;
         n = $fgets(line, fd);
         n = $sscanf(line, "%d %s %h %h %h %h %h", rec_t, rec_kind,
                     rec_a, rec_b, rec_c, rec_d, rec_e);
         ok = (n >= 3);   // comment and blank lines give less
      end
   endtask

   task automatic run_record();
      logic                   ok;
      logic [31:0]            w_addr;
      logic [31:0]            w_data;
      logic [`LUT_STRB_W-1:0] w_strb;
      logic                   w_err;
      int                     ov;
      w_addr = rec_a;
      w_data = rec_b;
      w_strb = rec_c[`LUT_STRB_W-1:0];
      w_err  = rec_d[0];
      ov     = rec_e;
      case (rec_kind)
         "W": begin
            if (ov == 0) begin
               apb_access(w_addr, w_data, w_strb, 1'b1, w_err);
            end else begin
               // stream the next ov lookups while the write lands
               chk0.clear_stalls();
               fork
                  apb_access(w_addr, w_data, w_strb, 1'b1, w_err);
                  repeat (ov) begin
                     if (!aborted) begin
                        read_record(ok);
                        send_beat(rec_a, rec_b, rec_c, rec_d, rec_e[0]);
                     end
                  end
               join
               chk0.check_stalls(1);
            end
         end
         "R": apb_access(w_addr, '0, '0, 1'b0, 1'b1);
         "L": send_beat(rec_a, rec_b, rec_c, rec_d, rec_e[0]);
         default: abort_run("unknown record kind in verif/lut_patterns.txt");
      endcase
   endtask

   task automatic finish_test();
      int n;
      n = 0;
      while (chk0.outstanding() != 0 && n < 50) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (chk0.outstanding() != 0) begin
         abort_run("timeout waiting for outstanding results");
      end else if (chk0.errors == err_base) begin
         n_pass++;
         $display("test %0d finished: ok", cur_test);
      end else begin
         n_fail++;
         $display("test %0d finished: %0d errors", cur_test, chk0.errors - err_base);
      end
   endtask

   initial begin
      logic ok;
      rst      = 1'b1;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      pstrb    = '0;
      in_valid = 1'b0;
      in_req   = '0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      fd = $fopen("verif/lut_patterns.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open verif/lut_patterns.txt");
      end else begin
         read_record(ok);
         while (ok && !aborted) begin
            if (rec_t != cur_test) begin
               if (cur_test != 0) finish_test();
               cur_test = rec_t;
               err_base = chk0.errors;
            end
            if (!aborted) run_record();
            if (!aborted) read_record(ok);
         end
         $fclose(fd);
         if (!aborted) finish_test();
      end
      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (!aborted && n_fail == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- verif/lut_checker.sv
`include "lut_consts.svh"

module lut_checker
   import lut_pkg::*;
(
   input logic                   clk,
   input logic                   rst,
   input logic                   psel,
   input logic                   penable,
   input logic                   pready,
   input logic                   pslverr,
   input logic [`LUT_DATA_W-1:0] prdata,
   input logic                   in_valid,
   input logic                   in_ready,
   input logic                   out_valid,
   input lut_rsp_t               out_rsp
);

   lut_rsp_t rsp_q [$];   // lookup results, oldest first
   logic     err_q [$];   // pslverr per APB access
   int       errors = 0;
   int       waits  = 0;
   int       stalls = 0;

   task automatic expect_rsp(input logic [31:0] v0, input logic [31:0] v1);
      rsp_q.push_back('{val0: v0, val1: v1});
   endtask

   task automatic expect_apb(input logic err);
      err_q.push_back(err);
   endtask

   function automatic int outstanding();
      return rsp_q.size() + err_q.size();
   endfunction

   task automatic clear_stalls();
      stalls = 0;
   endtask

   task automatic check_stalls(input int n);
      if (stalls != n) begin
         $display("[FAIL] %0t: in_ready low for %0d cycles, expected %0d", $time, stalls, n);
         errors++;
      end
   endtask

   // ############################
   // APB and result monitor
   // ############################

   always @(posedge clk) begin
      lut_rsp_t want;
      logic     err_want;
      if (!rst) begin
         if (in_valid && !in_ready) stalls++;
         if (psel && penable && !pready) waits++;
         if (psel && penable && pready) begin
            if (err_q.size() == 0) begin
               $display("APB access completed at %0t with no access expected", $time);
               errors++;
            end else begin
               err_want = err_q.pop_front();
               // accepted writes take one wait state, rejects none
               if (pslverr !== err_want || waits != (err_want ? 0 : 1) || prdata !== '0) begin
                  $display("[FAIL] %0t: APB pslverr %0b waits %0d prdata %h, expected %0b %0d 0",
                           $time, pslverr, waits, prdata, err_want, err_want ? 0 : 1);
                  errors++;
               end
            end
            waits = 0;
         end
         if (out_valid) begin
            if (rsp_q.size() == 0) begin
               $display("out_valid at %0t with no lookup outstanding", $time);
               errors++;
            end else begin
               want = rsp_q.pop_front();
               if (out_rsp !== want) begin
                  $display("[FAIL] %0t: lookup gave %h %h, expected %h %h", $time,
                           out_rsp.val0, out_rsp.val1, want.val0, want.val1);
                  errors++;
               end
            end
         end
      end
   end

endmodule

//--- hdl/lut_top.sv
`include "lut_consts.svh"

module lut_top
   import lut_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic [31:0]            paddr,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`LUT_DATA_W-1:0] pwdata,
   input  logic [`LUT_STRB_W-1:0] pstrb,
   output logic [`LUT_DATA_W-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   input  logic                   in_valid,
   input  lut_req_t               in_req,
   output logic                   in_ready,
   output logic                   out_valid,
   output lut_rsp_t               out_rsp
);

   lut_wr_t                wr;
   logic                   wr_done;
   dp_port_t               port_a;
   dp_port_t               port_b;
   logic [`LUT_DATA_W-1:0] rdata_a;
   logic [`LUT_DATA_W-1:0] rdata_b;

   lut_apb_port apb0 (
      .clk(clk), .rst(rst),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .pstrb(pstrb),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .wr(wr), .wr_done(wr_done)
   );

   lut_unit unit0 (
      .clk(clk), .rst(rst),
      .wr(wr), .wr_done(wr_done),
      .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
      .out_valid(out_valid), .out_rsp(out_rsp),
      .port_a(port_a), .port_b(port_b),
      .rdata_a(rdata_a), .rdata_b(rdata_b)
   );

   lut_dp_ram ram0 (
      .clk(clk),
      .port_a_addr(port_a.addr), .port_a_wdata(port_a.wdata),
      .port_a_en(port_a.en), .port_a_we(port_a.we),
      .port_b_addr(port_b.addr), .port_b_en(port_b.en),
      .rdata_a(rdata_a), .rdata_b(rdata_b)
   );

endmodule

//--- hdl/lut_unit.sv
`include "lut_consts.svh"

module lut_unit
   import lut_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  lut_wr_t                wr,
   output logic                   wr_done,
   input  logic                   in_valid,
   input  lut_req_t               in_req,
   output logic                   in_ready,
   output logic                   out_valid,
   output lut_rsp_t               out_rsp,
   output dp_port_t               port_a,
   output dp_port_t               port_b,
   input  logic [`LUT_DATA_W-1:0] rdata_a,
   input  logic [`LUT_DATA_W-1:0] rdata_b
);

   logic                   wr_pend;
   logic [`LUT_ADDR_W-1:0] wr_addr;
   logic [`LUT_DATA_W-1:0] wr_data;
   logic                   accept;
   logic                   rd_v;    // RAM read in flight
   logic                   out_v;   // output register loaded

   // ############################
   // write request
   // ############################

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_pend <= 1'b0;
      end else begin
         wr_pend <= wr.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (wr.valid) begin
         wr_addr <= wr.addr;
         wr_data <= wr.wdata;
      end
   end

   assign wr_done  = wr_pend;    // write lands this cycle
   assign in_ready = !wr_pend;   // port A busy
   assign accept   = in_valid && in_ready;

   // ############################
   // RAM ports
   // ############################

   always_comb begin
      port_a.addr  = wr_pend ? wr_addr : in_req.idx0[`LUT_ADDR_W-1:0];
      port_a.wdata = wr_data;
      port_a.en    = wr_pend || accept;
      port_a.we    = wr_pend;
      port_b.addr  = in_req.idx1[`LUT_ADDR_W-1:0];
      port_b.wdata = '0;
      port_b.en    = accept;
      port_b.we    = 1'b0;   // read only
   end

   // ############################
   // result pipe
   // ############################

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_v  <= 1'b0;
         out_v <= 1'b0;
      end else begin
         rd_v  <= accept;
         out_v <= rd_v;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_v) begin
         out_rsp <= '{val0: rdata_a, val1: rdata_b};
      end
   end

   assign out_valid = out_v;

   a_no_accept_on_write: assert property (@(posedge clk) disable iff (rst)
      wr.valid |=> !(in_valid && in_ready));
   a_out_latency: assert property (@(posedge clk) disable iff (rst)
      (in_valid && in_ready) |-> ##2 out_valid);

endmodule

//--- hdl/lut_apb_port.sv
`include "lut_consts.svh"

module lut_apb_port
   import lut_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic [31:0]            paddr,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`LUT_DATA_W-1:0] pwdata,
   input  logic [`LUT_STRB_W-1:0] pstrb,
   output logic [`LUT_DATA_W-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   output lut_wr_t                wr,
   input  logic                   wr_done
);

   logic                   setup;
   logic                   accept;
   logic                   wr_valid_q;
   logic [`LUT_ADDR_W-1:0] wr_addr_q;
   logic [`LUT_DATA_W-1:0] wr_data_q;
   logic                   err_q;
   logic                   wr_wait;

   assign setup  = psel && !penable;
   assign accept = pwrite && (|pstrb) && (paddr[31:2] < `LUT_DEPTH);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_valid_q <= 1'b0;
         err_q      <= 1'b0;
         wr_wait    <= 1'b0;
      end else begin
         wr_valid_q <= setup && accept;   // high in first access cycle
         err_q      <= setup && !accept;
         if (setup && accept) begin
            wr_wait <= 1'b1;
         end else if (wr_done) begin
            wr_wait <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (setup && accept) begin
         wr_addr_q <= paddr[`LUT_ADDR_W+1:2];   // word addressed
         wr_data_q <= pwdata;
      end
   end

   assign wr      = '{valid: wr_valid_q, addr: wr_addr_q, wdata: wr_data_q};
   assign pready  = err_q || (wr_wait && wr_done);   // one wait state on writes
   assign pslverr = err_q;
   assign prdata  = '0;   // no host reads

   a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);
   a_done_outstanding: assert property (@(posedge clk) disable iff (rst) wr_done |-> wr_wait);

endmodule

//--- hdl/lut_dp_ram.sv
`include "lut_consts.svh"

module lut_dp_ram (
   input  logic                   clk,
   input  logic [`LUT_ADDR_W-1:0] port_a_addr,
   input  logic [`LUT_DATA_W-1:0] port_a_wdata,
   input  logic                   port_a_en,
   input  logic                   port_a_we,
   input  logic [`LUT_ADDR_W-1:0] port_b_addr,
   input  logic                   port_b_en,
   output logic [`LUT_DATA_W-1:0] rdata_a,
   output logic [`LUT_DATA_W-1:0] rdata_b
);

   logic [`LUT_DATA_W-1:0] mem [`LUT_DEPTH];

   // table starts out cleared
   initial begin
      for (int i = 0; i < `LUT_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // ############################
   // port A, read/write
   // ############################

   always @(posedge clk) begin
      if (port_a_en) begin
         if (port_a_we) begin
            mem[port_a_addr] <= port_a_wdata;
         end
         rdata_a <= mem[port_a_addr];   // read-first
      end
   end

   // ############################
   // port B, read only
   // ############################

   always_ff @(posedge clk) begin
      if (port_b_en) begin
         rdata_b <= mem[port_b_addr];
      end
   end

endmodule

//--- hdl/lut_pkg.sv
`include "lut_consts.svh"

package lut_pkg;

   // ############################
   // host write path
   // ############################

   typedef struct packed {
      logic                   valid;   // one-cycle strobe
      logic [`LUT_ADDR_W-1:0] addr;    // entry number
      logic [`LUT_DATA_W-1:0] wdata;
   } lut_wr_t;

   // ############################
   // lookup stream
   // ############################

   typedef struct packed {
      logic [`LUT_DATA_W-1:0] idx0;    // only low addr bits used
      logic [`LUT_DATA_W-1:0] idx1;
   } lut_req_t;

   typedef struct packed {
      logic [`LUT_DATA_W-1:0] val0;    // table[idx0]
      logic [`LUT_DATA_W-1:0] val1;    // table[idx1]
   } lut_rsp_t;

   // one RAM port command
   typedef struct packed {
      logic [`LUT_ADDR_W-1:0] addr;
      logic [`LUT_DATA_W-1:0] wdata;
      logic                   en;
      logic                   we;
   } dp_port_t;

endpackage

//--- hdl/lut_consts.svh
`ifndef LUT_CONSTS_SVH
`define LUT_CONSTS_SVH

// ############################
// table geometry
// ############################

// one table word, also the width of a lookup index on the stream
`define LUT_DATA_W 32

// entry select, low bits of each index
`define LUT_ADDR_W 8

// entries in the table
`define LUT_DEPTH  256

// APB byte strobes per table word
`define LUT_STRB_W (`LUT_DATA_W / 8)

`endif
